// File: axi_log_pkg.sv
package axi_log_pkg;

    // ####################
    // bus widths
    // ####################

    localparam int id_w       = 4;
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int chan_count = 5;

    // bit positions of the channels in req and grant.
    localparam int ch_ar = 0;
    localparam int ch_aw = 1;
    localparam int ch_w  = 2;
    localparam int ch_r  = 3;
    localparam int ch_b  = 4;

    // ####################
    // channel payloads
    // ####################

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } addr_chan_t;

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [data_w/8-1:0] strb;
        logic                last;
    } w_chan_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_chan_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_chan_t;

    // ####################
    // log record
    // ####################

    typedef enum logic [3:0] {
        ev_ar = 4'd1,
        ev_aw = 4'd2,
        ev_r  = 4'd3,
        ev_w  = 4'd4,
        ev_b  = 4'd5
    } log_event_e;

    localparam int body_w      = $bits(addr_chan_t);
    localparam int data_view_w = id_w + data_w + data_w / 8 + 2 + 1;

    // data side of the body, zero padded up to the address view.
    typedef struct packed {
        logic [body_w-data_view_w-1:0] pad;
        logic [id_w-1:0]               id;
        logic [data_w-1:0]             data;
        logic [data_w/8-1:0]           strb;
        logic [1:0]                    resp;
        logic                          last;
    } data_view_t;

    // AR/AW records read addr_view, W/R/B records read data_view.
    typedef union packed {
        addr_chan_t addr_view;
        data_view_t data_view;
    } log_body_u;

    typedef struct packed {
        log_event_e event_code;
        log_body_u  body;
    } log_record_t;

endpackage

// File: axi_channel_tap.sv
`timescale 1ns/1ns

module axi_channel_tap (
    input  logic                                s_ar_valid,
    output logic                                s_ar_ready,
    input  axi_log_pkg::addr_chan_t             s_ar,
    input  logic                                s_aw_valid,
    output logic                                s_aw_ready,
    input  axi_log_pkg::addr_chan_t             s_aw,
    input  logic                                s_w_valid,
    output logic                                s_w_ready,
    input  axi_log_pkg::w_chan_t                s_w,
    output logic                                s_r_valid,
    input  logic                                s_r_ready,
    output axi_log_pkg::r_chan_t                s_r,
    output logic                                s_b_valid,
    input  logic                                s_b_ready,
    output axi_log_pkg::b_chan_t                s_b,
    output logic                                m_ar_valid,
    input  logic                                m_ar_ready,
    output axi_log_pkg::addr_chan_t             m_ar,
    output logic                                m_aw_valid,
    input  logic                                m_aw_ready,
    output axi_log_pkg::addr_chan_t             m_aw,
    output logic                                m_w_valid,
    input  logic                                m_w_ready,
    output axi_log_pkg::w_chan_t                m_w,
    input  logic                                m_r_valid,
    output logic                                m_r_ready,
    input  axi_log_pkg::r_chan_t                m_r,
    input  logic                                m_b_valid,
    output logic                                m_b_ready,
    input  axi_log_pkg::b_chan_t                m_b,
    output logic [axi_log_pkg::chan_count-1:0]  req,
    input  logic [axi_log_pkg::chan_count-1:0]  grant,
    output axi_log_pkg::log_record_t            record
);
    import axi_log_pkg::*;

    // a channel asks for a slot once both of its sides could move.
    assign req[ch_ar] = s_ar_valid & m_ar_ready;
    assign req[ch_aw] = s_aw_valid & m_aw_ready;
    assign req[ch_w]  = s_w_valid  & m_w_ready;
    assign req[ch_r]  = m_r_valid  & s_r_ready;
    assign req[ch_b]  = m_b_valid  & s_b_ready;

    // both halves of the handshake open only with the grant.
    assign s_ar_ready = m_ar_ready & grant[ch_ar];
    assign m_ar_valid = s_ar_valid & grant[ch_ar];
    assign s_aw_ready = m_aw_ready & grant[ch_aw];
    assign m_aw_valid = s_aw_valid & grant[ch_aw];
    assign s_w_ready  = m_w_ready  & grant[ch_w];
    assign m_w_valid  = s_w_valid  & grant[ch_w];
    assign m_r_ready  = s_r_ready  & grant[ch_r];
    assign s_r_valid  = m_r_valid  & grant[ch_r];
    assign m_b_ready  = s_b_ready  & grant[ch_b];
    assign s_b_valid  = m_b_valid  & grant[ch_b];

    assign m_ar = s_ar;
    assign m_aw = s_aw;
    assign m_w  = s_w;
    assign s_r  = m_r;
    assign s_b  = m_b;

    // record body of the granted channel, unused fields stay zero.
    always_comb begin
        record = '0;
        if (grant[ch_ar]) begin
            record.event_code     = ev_ar;
            record.body.addr_view = s_ar;
        end else if (grant[ch_aw]) begin
            record.event_code     = ev_aw;
            record.body.addr_view = s_aw;
        end else if (grant[ch_w]) begin
            record.event_code          = ev_w;
            record.body.data_view.data = s_w.data;
            record.body.data_view.strb = s_w.strb;
            record.body.data_view.last = s_w.last;
        end else if (grant[ch_r]) begin
            record.event_code          = ev_r;
            record.body.data_view.id   = m_r.id;
            record.body.data_view.data = m_r.data;
            record.body.data_view.resp = m_r.resp;
            record.body.data_view.last = m_r.last;
        end else if (grant[ch_b]) begin
            record.event_code          = ev_b;
            record.body.data_view.id   = m_b.id;
            record.body.data_view.resp = m_b.resp;
        end
    end

endmodule

// File: log_arbiter.sv
`timescale 1ns/1ns

module log_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [axi_log_pkg::chan_count-1:0]  req,
    input  logic                                accept,
    output logic [axi_log_pkg::chan_count-1:0]  grant
);
    import axi_log_pkg::*;

    localparam int ptr_w = $clog2(chan_count);

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] sel;
    logic             hit;

    // ####################
    // search from the pointer
    // ####################

    // walk downwards so the nearest requester to ptr wins.
    always_comb begin
        int unsigned idx;
        sel = '0;
        hit = 1'b0;
        for (int i = chan_count - 1; i >= 0; i--) begin
            idx = ptr + i;
            if (idx >= chan_count) begin
                idx = idx - chan_count;
            end
            if (req[idx]) begin
                sel = ptr_w'(idx);
                hit = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (hit && accept) begin
            grant[sel] = 1'b1;
        end
    end

    // pointer moves past the winner.
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (hit && accept) begin
            if (sel == ptr_w'(chan_count - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= sel + 1'b1;
            end
        end
    end

endmodule

// File: log_stamper.sv
`timescale 1ns/1ns

module log_stamper #(
    parameter int STAMP_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          take,
    input  axi_log_pkg::log_record_t      record,
    output logic                          accept,
    output logic                          log_valid,
    output axi_log_pkg::log_record_t      log_record,
    output logic [STAMP_WIDTH-1:0]        log_stamp,
    input  logic                          log_ready
);

    logic [STAMP_WIDTH-1:0] cycle_cnt;
    logic                   full;

    // ####################
    // cycle counter
    // ####################

    // holds 0 in reset, so after edge N it reads N.
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // ####################
    // output register
    // ####################

    // room when empty or when the current entry drains this cycle.
    assign accept    = !full || log_ready;
    assign log_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (log_ready) begin
            full <= 1'b0;
        end
    end

    // stamp counts the loading edge itself.
    always_ff @(posedge clk) begin
        if (take) begin
            log_record <= record;
            log_stamp  <= cycle_cnt + 1'b1;
        end
    end

endmodule

// File: axi_logger_top.sv
`timescale 1ns/1ns

module axi_logger_top #(
    parameter int STAMP_WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    // slave side, faces the master.
    input  logic                        s_ar_valid,
    output logic                        s_ar_ready,
    input  axi_log_pkg::addr_chan_t     s_ar,
    input  logic                        s_aw_valid,
    output logic                        s_aw_ready,
    input  axi_log_pkg::addr_chan_t     s_aw,
    input  logic                        s_w_valid,
    output logic                        s_w_ready,
    input  axi_log_pkg::w_chan_t        s_w,
    output logic                        s_r_valid,
    input  logic                        s_r_ready,
    output axi_log_pkg::r_chan_t        s_r,
    output logic                        s_b_valid,
    input  logic                        s_b_ready,
    output axi_log_pkg::b_chan_t        s_b,
    // master side, faces the slave.
    output logic                        m_ar_valid,
    input  logic                        m_ar_ready,
    output axi_log_pkg::addr_chan_t     m_ar,
    output logic                        m_aw_valid,
    input  logic                        m_aw_ready,
    output axi_log_pkg::addr_chan_t     m_aw,
    output logic                        m_w_valid,
    input  logic                        m_w_ready,
    output axi_log_pkg::w_chan_t        m_w,
    input  logic                        m_r_valid,
    output logic                        m_r_ready,
    input  axi_log_pkg::r_chan_t        m_r,
    input  logic                        m_b_valid,
    output logic                        m_b_ready,
    input  axi_log_pkg::b_chan_t        m_b,
    // log port.
    output logic                        log_valid,
    input  logic                        log_ready,
    output axi_log_pkg::log_record_t    log_record,
    output logic [STAMP_WIDTH-1:0]      log_stamp
);
    import axi_log_pkg::*;

    logic [chan_count-1:0] req;
    logic [chan_count-1:0] grant;
    log_record_t           record;
    logic                  accept;

    axi_channel_tap u_tap (
        .s_ar_valid (s_ar_valid), .s_ar_ready (s_ar_ready), .s_ar (s_ar),
        .s_aw_valid (s_aw_valid), .s_aw_ready (s_aw_ready), .s_aw (s_aw),
        .s_w_valid  (s_w_valid),  .s_w_ready  (s_w_ready),  .s_w  (s_w),
        .s_r_valid  (s_r_valid),  .s_r_ready  (s_r_ready),  .s_r  (s_r),
        .s_b_valid  (s_b_valid),  .s_b_ready  (s_b_ready),  .s_b  (s_b),
        .m_ar_valid (m_ar_valid), .m_ar_ready (m_ar_ready), .m_ar (m_ar),
        .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready), .m_aw (m_aw),
        .m_w_valid  (m_w_valid),  .m_w_ready  (m_w_ready),  .m_w  (m_w),
        .m_r_valid  (m_r_valid),  .m_r_ready  (m_r_ready),  .m_r  (m_r),
        .m_b_valid  (m_b_valid),  .m_b_ready  (m_b_ready),  .m_b  (m_b),
        .req        (req),
        .grant      (grant),
        .record     (record)
    );

    log_arbiter u_arb (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .accept (accept),
        .grant  (grant)
    );

    // any grant loads the output register.
    log_stamper #(
        .STAMP_WIDTH (STAMP_WIDTH)
    ) u_stamp (
        .clk        (clk),
        .rst        (rst),
        .take       (|grant),
        .record     (record),
        .accept     (accept),
        .log_valid  (log_valid),
        .log_record (log_record),
        .log_stamp  (log_stamp),
        .log_ready  (log_ready)
    );

endmodule

// File: axi_logger_assert.sv
`timescale 1ns/1ns

module axi_logger_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     s_ar_valid, s_ar_ready, m_ar_valid, m_ar_ready,
    input logic                     s_aw_valid, s_aw_ready, m_aw_valid, m_aw_ready,
    input logic                     s_w_valid, s_w_ready, m_w_valid, m_w_ready,
    input logic                     m_r_valid, m_r_ready, s_r_valid, s_r_ready,
    input logic                     m_b_valid, m_b_ready, s_b_valid, s_b_ready,
    input logic                     log_valid,
    input logic                     log_ready,
    input axi_log_pkg::log_record_t log_record
);

    // one channel transfer per cycle at most.
    one_transfer: assert property (@(posedge clk) disable iff (rst)
        $onehot0({s_ar_valid && s_ar_ready, s_aw_valid && s_aw_ready,
                  s_w_valid && s_w_ready, s_r_valid && s_r_ready, s_b_valid && s_b_ready}))
        else $error("more than one channel transfer in a cycle");

    log_hold: assert property (@(posedge clk) disable iff (rst)
        log_valid && !log_ready |=> log_valid && $stable(log_record))
        else $error("log record changed while stalled");

    // output side valid needs the input side valid.
    valid_src: assert property (@(posedge clk) disable iff (rst)
        (!m_ar_valid || s_ar_valid) && (!m_aw_valid || s_aw_valid) && (!m_w_valid || s_w_valid)
        && (!s_r_valid || m_r_valid) && (!s_b_valid || m_b_valid))
        else $error("forwarded valid without a source valid");

endmodule

bind axi_logger_top axi_logger_assert u_assert (.*);

// File: tb_axi_logger.sv
`timescale 1ns/1ns

module tb_axi_logger;
    import axi_log_pkg::*;

    typedef struct packed {
        log_record_t rec;
        logic [31:0] stamp;
    } exp_t;

    localparam int run_cycles = 1800;
    localparam int timeout_ns = 3000 * 8;

    logic clk = 1'b0;
    logic rst;
    logic s_ar_valid, s_ar_ready, s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
    logic s_r_valid, s_r_ready, s_b_valid, s_b_ready;
    logic m_ar_valid, m_ar_ready, m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
    logic m_r_valid, m_r_ready, m_b_valid, m_b_ready;
    addr_chan_t  s_ar, s_aw, m_ar, m_aw;
    w_chan_t     s_w, m_w;
    r_chan_t     s_r, m_r;
    b_chan_t     s_b, m_b;
    logic        log_valid, log_ready;
    log_record_t log_record;
    logic [31:0] log_stamp;

    integer      seed;
    logic        stop;
    logic [8:0]  phase_cnt;
    int          edges;
    int          records;
    int          waits [chan_count];
    exp_t        exp_q [$];

    always #4 clk = ~clk;

    axi_logger_top #(.STAMP_WIDTH(32)) u_dut (.*);

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_error(input string what);
        $display("%0t %s", $time, what);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    // expected record from the channel rules, address or data view.
    function automatic log_record_t expected_record(input logic [3:0] code,
            input addr_chan_t addr_word, input logic [3:0] id, input logic [31:0] data,
            input logic [3:0] strb, input logic [1:0] resp, input logic last);
        if (code == 4'd1 || code == 4'd2) begin
            return {code, addr_word};
        end
        return {code, {(body_w - data_view_w){1'b0}}, id, data, strb, resp, last};
    endfunction

    function automatic addr_chan_t random_addr();
        addr_chan_t  a;
        logic [31:0] r;
        r       = $random(seed);
        a.id    = r[3:0];
        a.len   = r[11:4];
        a.size  = r[14:12];
        a.burst = r[16:15];
        a.addr  = $random(seed);
        return a;
    endfunction

    // ####################
    // master, slave, sink
    // ####################

    always @(posedge clk) begin
        phase_cnt <= rst ? 9'd0 : phase_cnt + 1'b1;
    end

    always @(posedge clk) begin : drive_master
        logic [31:0] r;
        logic        sat;
        r   = $random(seed);
        sat = (phase_cnt[8:7] == 2'd2);
        if (rst) begin
            s_ar_valid <= 1'b0;
            s_aw_valid <= 1'b0;
            s_w_valid  <= 1'b0;
        end else begin
            if (!s_ar_valid || s_ar_ready) begin
                s_ar_valid <= !stop && (sat || r[0]);
                s_ar       <= random_addr();
            end
            if (!s_aw_valid || s_aw_ready) begin
                s_aw_valid <= !stop && (sat || r[1]);
                s_aw       <= random_addr();
            end
            if (!s_w_valid || s_w_ready) begin
                s_w_valid <= !stop && (sat || r[2]);
                s_w       <= {$random(seed), r[11:8], r[12]};
            end
        end
        s_r_ready <= stop || sat || r[3];
        s_b_ready <= stop || sat || r[4];
    end

    always @(posedge clk) begin : drive_slave
        logic [31:0] r;
        logic        sat;
        r   = $random(seed);
        sat = (phase_cnt[8:7] == 2'd2);
        if (rst) begin
            m_r_valid <= 1'b0;
            m_b_valid <= 1'b0;
        end else begin
            if (!m_r_valid || m_r_ready) begin
                m_r_valid <= !stop && (sat || r[0]);
                m_r       <= {r[7:4], $random(seed), r[9:8], r[10]};
            end
            if (!m_b_valid || m_b_ready) begin
                m_b_valid <= !stop && (sat || r[1]);
                m_b       <= {r[15:12], r[17:16]};
            end
        end
        m_ar_ready <= stop || sat || r[2];
        m_aw_ready <= stop || sat || r[3];
        m_w_ready  <= stop || sat || r[18];
    end

    // phase 3 holds the log port mostly stalled.
    always @(posedge clk) begin : drive_sink
        logic [31:0] r;
        r = $random(seed);
        if (stop || phase_cnt[8:7] == 2'd2) begin
            log_ready <= 1'b1;
        end else if (phase_cnt[8:7] == 2'd3) begin
            log_ready <= (r[2:0] == 3'd0);
        end else begin
            log_ready <= r[0];
        end
    end

    // ####################
    // monitor and compare
    // ####################

    always @(posedge clk) begin : monitor
        logic [4:0] req;
        logic [4:0] done;
        int         held;
        if (rst) begin
            edges = 0;
            held  = 0;
            for (int c = 0; c < chan_count; c++) waits[c] = 0;
        end else begin
            edges = edges + 1;
            if (edges == 1) begin
                assert (!log_valid) else report_value("log_valid", 64'd0, 64'(log_valid));
            end
            req  = {m_b_valid && s_b_ready, m_r_valid && s_r_ready, s_w_valid && m_w_ready,
                    s_aw_valid && m_aw_ready, s_ar_valid && m_ar_ready};
            done = {s_b_valid && s_b_ready, s_r_valid && s_r_ready, s_w_valid && s_w_ready,
                    s_aw_valid && s_aw_ready, s_ar_valid && s_ar_ready};
            // nothing moves toward either side without a source valid.
            assert ((s_ar_valid || (!m_ar_valid && !s_ar_ready))
                    && (s_aw_valid || (!m_aw_valid && !s_aw_ready))
                    && (s_w_valid || (!m_w_valid && !s_w_ready))
                    && (m_r_valid || (!s_r_valid && !m_r_ready))
                    && (m_b_valid || (!s_b_valid && !m_b_ready)))
                else report_error("DUT handshake signal high without a request");
            assert (done == {m_b_valid && m_b_ready, m_r_valid && m_r_ready,
                             m_w_valid && m_w_ready, m_aw_valid && m_aw_ready,
                             m_ar_valid && m_ar_ready})
                else report_error("transfer completed on only one side of a channel");
            assert (m_ar == s_ar) else report_value("m_ar", 64'(s_ar), 64'(m_ar));
            assert (m_aw == s_aw) else report_value("m_aw", 64'(s_aw), 64'(m_aw));
            assert (m_w == s_w) else report_value("m_w", 64'(s_w), 64'(m_w));
            assert (s_r == m_r) else report_value("s_r", 64'(m_r), 64'(s_r));
            assert (s_b == m_b) else report_value("s_b", 64'(m_b), 64'(s_b));
            if (done[0]) exp_q.push_back({expected_record(4'd1, s_ar, 4'd0, 32'd0, 4'd0,
                                          2'd0, 1'b0), 32'(edges)});
            if (done[1]) exp_q.push_back({expected_record(4'd2, s_aw, 4'd0, 32'd0, 4'd0,
                                          2'd0, 1'b0), 32'(edges)});
            if (done[2]) exp_q.push_back({expected_record(4'd4, '0, 4'd0, s_w.data,
                                          s_w.strb, 2'd0, s_w.last), 32'(edges)});
            if (done[3]) exp_q.push_back({expected_record(4'd3, '0, m_r.id, m_r.data,
                                          4'd0, m_r.resp, m_r.last), 32'(edges)});
            if (done[4]) exp_q.push_back({expected_record(4'd5, '0, m_b.id, 32'd0,
                                          4'd0, m_b.resp, 1'b0), 32'(edges)});
            // the output register holds one record, so transfers lead the log port by one.
            if (done != 5'd0) begin
                held = held + 1;
            end
            if (log_valid && log_ready) begin
                held = held - 1;
            end
            assert (held <= 1)
                else report_error("more transfers completed than the log register can hold");
            // a requesting channel may see at most chan_count-1 others pass it.
            for (int c = 0; c < chan_count; c++) begin
                if (done[c] || !req[c]) begin
                    waits[c] = 0;
                end else if (done != 5'd0) begin
                    waits[c] = waits[c] + 1;
                end
                assert (waits[c] < chan_count)
                    else report_error("a requesting channel was starved");
            end
        end
    end

    always @(posedge clk) begin : compare
        exp_t e;
        if (!rst && log_valid && log_ready) begin
            if (exp_q.size() == 0) begin
                report_error("log record without a matching transfer");
            end else begin
                e = exp_q.pop_front();
                assert (log_record.event_code == e.rec.event_code)
                    else report_value("log_record.event_code", 64'(e.rec.event_code),
                                      64'(log_record.event_code));
                assert (log_record.body == e.rec.body)
                    else report_value("log_record.body", 64'(e.rec.body),
                                      64'(log_record.body));
                assert (log_stamp == e.stamp)
                    else report_value("log_stamp", 64'(e.stamp), 64'(log_stamp));
                records = records + 1;
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout, the log port never drained");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed       = 57;
        records    = 0;
        stop       = 1'b0;
        rst        = 1'b1;
        phase_cnt  = '0;
        s_ar_valid = 1'b0;
        s_aw_valid = 1'b0;
        s_w_valid  = 1'b0;
        s_ar       = '0;
        s_aw       = '0;
        s_w        = '0;
        s_r_ready  = 1'b0;
        s_b_ready  = 1'b0;
        m_ar_ready = 1'b0;
        m_aw_ready = 1'b0;
        m_w_ready  = 1'b0;
        m_r_valid  = 1'b0;
        m_b_valid  = 1'b0;
        m_r        = '0;
        m_b        = '0;
        log_ready  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (run_cycles) @(posedge clk);
        stop <= 1'b1;
        @(posedge clk);
        while (exp_q.size() != 0 || log_valid || s_ar_valid || s_aw_valid || s_w_valid
               || m_r_valid || m_b_valid) begin
            @(posedge clk);
        end
        if (records > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "no records were logged");
        end
    end

endmodule

// File: list.f
axi_log_pkg.sv
axi_channel_tap.sv
log_arbiter.sv
log_stamper.sv
axi_logger_top.sv
axi_logger_assert.sv
tb_axi_logger.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_axi_logger
FLIST = list.f
LOG   = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
